// ==== common/sifh_config.svh ====
`ifndef SIFH_CONFIG_SVH
`define SIFH_CONFIG_SVH

// sizing of the time-of-flight histogrammer

// pixels served by one histogram memory
`define SIFH_PIXEL_NUM 4

// bins per pixel, kept a power of two
`define SIFH_BIN_NUM 32

// raw timestamp width from the host
`define SIFH_TS_WIDTH 10

// low timestamp bits dropped to form the bin index
// 10 bit stamp >> 5 gives 32 bins exactly
`define SIFH_BIN_SHIFT 5

// bin counter width, saturates at all ones
`define SIFH_COUNT_WIDTH 8

`endif

// ==== common/sifhPkg.sv ====
`include "sifh_config.svh"

package sifhPkg;

    // sizes pulled from the config header
    localparam int PIXEL_NUM = `SIFH_PIXEL_NUM;
    localparam int BIN_NUM = `SIFH_BIN_NUM;
    localparam int TS_W = `SIFH_TS_WIDTH;
    localparam int BIN_SHIFT = `SIFH_BIN_SHIFT;
    localparam int COUNT_W = `SIFH_COUNT_WIDTH;

    // derived widths
    localparam int PIXEL_W = $clog2(PIXEL_NUM);
    localparam int BIN_W = $clog2(BIN_NUM);
    localparam int ADDR_W = PIXEL_W + BIN_W;
    // one histogram per pixel, stacked by pixel
    localparam int HIST_DEPTH = PIXEL_NUM * BIN_NUM;

    typedef logic [PIXEL_W-1:0] pixelIdxT;
    typedef logic [BIN_W-1:0] binIdxT;
    // address is {pixel, bin}
    typedef logic [ADDR_W-1:0] histAddrT;
    typedef logic [TS_W-1:0] timestampT;
    typedef logic [COUNT_W-1:0] countT;

    // all ones stamp means no photon in this window
    localparam timestampT NO_HIT = '1;
    // saturation ceiling of a bin
    localparam countT COUNT_MAX = '1;
    // bus address that closes a frame
    localparam logic [2:0] EOF_ADR = 3'd4;

endpackage

// ==== design/timestampBinner.sv ====
`timescale 1ns/100ps

module timestampBinner (
    input  logic               clk,
    input  logic               rstN,
    // wishbone classic slave
    input  logic               cyc,
    input  logic               stb,
    input  logic               we,
    input  logic [2:0]         adr,
    input  sifhPkg::timestampT dat,
    output logic               ack,
    // stall from the accumulator
    input  logic               busy,
    // hit stream to the accumulator
    output logic               hitValid,
    output sifhPkg::pixelIdxT  hitPixel,
    output sifhPkg::binIdxT    hitBin,
    output logic               eofPulse
);
    import sifhPkg::*;

    logic      accept;
    logic      isHitAdr;
    logic      inRange;
    timestampT binned;

    // take a request once per bus cycle
    // registered ack blocks the cycle right after an accept
    assign accept = cyc && stb && !ack && !busy;

    // pixel writes live at adr 0..PIXEL_NUM-1
    assign isHitAdr = we && (int'(adr) < PIXEL_NUM);

    // coarse bin is the stamp without its low bits
    assign binned = dat >> BIN_SHIFT;

    // no-hit marker and bins past the end are acked but dropped
    // with the default sizes only the marker can trip this
    assign inRange = (dat != NO_HIT) && (int'(binned) < BIN_NUM);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ack      <= 1'b0;
            hitValid <= 1'b0;
            eofPulse <= 1'b0;
        end else begin
            // reads are acked too, there is no data to return
            ack      <= accept;
            hitValid <= accept && isHitAdr && inRange;
            eofPulse <= accept && we && (adr == EOF_ADR);
        end
    end

    // payload only, qualified by hitValid downstream
    always_ff @(posedge clk) begin
        if (accept) begin
            hitPixel <= adr[PIXEL_W-1:0];
            hitBin   <= binned[BIN_W-1:0];
        end
    end

endmodule

// ==== histogram/histogramRam.sv ====
`timescale 1ns/100ps

module histogramRam (
    input  logic              clk,
    // write port
    input  logic              wrEn,
    input  sifhPkg::histAddrT wrAddr,
    input  sifhPkg::countT    wrData,
    // read port, one cycle latency
    input  logic              rdEn,
    input  sifhPkg::histAddrT rdAddr,
    output sifhPkg::countT    rdData
);
    import sifhPkg::*;

    // one row per {pixel, bin}
    countT mem [HIST_DEPTH];

    // plain simple dual-port block ram
    // contents come up undefined, the accumulator sweeps them to zero
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // registered read
    // same-address write in the same cycle returns the old word
    // scan relies on that to read and clear in one go
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

// ==== histogram/histogramAccumulator.sv ====
`timescale 1ns/100ps

module histogramAccumulator (
    input  logic              clk,
    input  logic              rstN,
    // hits from the binner
    input  logic              hitValid,
    input  sifhPkg::pixelIdxT hitPixel,
    input  sifhPkg::binIdxT   hitBin,
    // end of frame in and delayed out
    input  logic              eofIn,
    output logic              eofOut,
    output logic              busy,
    // scan access from the peak finder
    input  logic              scanRdEn,
    input  sifhPkg::histAddrT scanAddr,
    output sifhPkg::countT    scanRdData,
    input  logic              scanDone
);
    import sifhPkg::*;

    // ownership of the memory
    logic     sweeping;
    logic     scanning;
    histAddrT sweepAddr;

    // rmw pipeline, p1 waits on read data, wr holds the write
    logic     p1Valid;
    histAddrT p1Addr;
    logic     wrValid;
    histAddrT wrAddrQ;
    countT    wrDataQ;

    // copy of the write that landed on the edge p1 was read
    logic     fwdValid;
    histAddrT fwdAddr;
    countT    fwdData;

    countT    baseCount;
    countT    nextCount;

    // memory side after arbitration
    logic     ramWrEn;
    histAddrT ramWrAddr;
    countT    ramWrData;
    logic     ramRdEn;
    histAddrT ramRdAddr;
    countT    ramRdData;

    // stall the bus while sweeping or scanning
    assign busy = sweeping || scanning;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            sweeping  <= 1'b1;
            sweepAddr <= '0;
            scanning  <= 1'b0;
            eofOut    <= 1'b0;
            p1Valid   <= 1'b0;
            wrValid   <= 1'b0;
            fwdValid  <= 1'b0;
        end else begin
            // one zero write per cycle over the whole array
            if (sweeping) begin
                sweepAddr <= sweepAddr + 1'b1;
                if (sweepAddr == '1) begin
                    sweeping <= 1'b0;
                end
            end
            // scan owns memory from eofOut until the last result leaves
            if (eofIn) begin
                scanning <= 1'b1;
            end else if (scanDone) begin
                scanning <= 1'b0;
            end
            // last hit write is already issued by now
            eofOut   <= eofIn;
            p1Valid  <= hitValid;
            wrValid  <= p1Valid;
            fwdValid <= ramWrEn;
        end
    end

    always_ff @(posedge clk) begin
        p1Addr  <= {hitPixel, hitBin};
        wrAddrQ <= p1Addr;
        wrDataQ <= nextCount;
        fwdAddr <= ramWrAddr;
        fwdData <= ramWrData;
    end

    // pick the freshest value for p1
    // the write in flight now beats the one that raced the read
    always_comb begin
        if (wrValid && (wrAddrQ == p1Addr)) begin
            baseCount = wrDataQ;
        end else if (fwdValid && (fwdAddr == p1Addr)) begin
            baseCount = fwdData;
        end else begin
            baseCount = ramRdData;
        end
    end

    // saturating increment
    assign nextCount = (baseCount == COUNT_MAX) ? baseCount : baseCount + 1'b1;

    always_comb begin
        if (sweeping) begin
            ramWrEn   = 1'b1;
            ramWrAddr = sweepAddr;
            ramWrData = '0;
            ramRdEn   = 1'b0;
            ramRdAddr = sweepAddr;
        end else if (scanning) begin
            // read and clear the same word
            ramWrEn   = scanRdEn;
            ramWrAddr = scanAddr;
            ramWrData = '0;
            ramRdEn   = scanRdEn;
            ramRdAddr = scanAddr;
        end else begin
            ramWrEn   = wrValid;
            ramWrAddr = wrAddrQ;
            ramWrData = wrDataQ;
            ramRdEn   = hitValid;
            ramRdAddr = {hitPixel, hitBin};
        end
    end

    assign scanRdData = ramRdData;

    histogramRam uRam (
        .clk    (clk),
        .wrEn   (ramWrEn),
        .wrAddr (ramWrAddr),
        .wrData (ramWrData),
        .rdEn   (ramRdEn),
        .rdAddr (ramRdAddr),
        .rdData (ramRdData)
    );

endmodule

// ==== design/peakFinder.sv ====
`timescale 1ns/100ps

module peakFinder (
    input  logic              clk,
    input  logic              rstN,
    input  logic              eofPulse,
    // scan port into the accumulator
    output logic              scanRdEn,
    output sifhPkg::histAddrT scanAddr,
    input  sifhPkg::countT    scanRdData,
    output logic              scanDone,
    // result stream
    output logic              peakValid,
    input  logic              peakReady,
    output sifhPkg::pixelIdxT peakPixel,
    output sifhPkg::binIdxT   peakBin,
    output sifhPkg::countT    peakCount
);
    import sifhPkg::*;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        DRAIN,
        HOLD
    } stateT;

    stateT    state;
    pixelIdxT pixel;
    binIdxT   bin;
    // read data lags the address by one cycle
    logic     cmpValid;
    binIdxT   cmpBin;
    binIdxT   maxBin;
    countT    maxCount;
    logic     lastPixel;
    logic     lastBin;

    assign lastPixel = (pixel == pixelIdxT'(PIXEL_NUM - 1));
    assign lastBin   = (bin == binIdxT'(BIN_NUM - 1));

    assign scanRdEn = (state == READ);
    assign scanAddr = {pixel, bin};

    // result sits here untouched until taken
    assign peakValid = (state == HOLD);
    assign peakPixel = pixel;
    assign peakBin   = maxBin;
    assign peakCount = maxCount;

    // frame done once the last pixel is handed over
    assign scanDone = peakValid && peakReady && lastPixel;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state    <= IDLE;
            pixel    <= '0;
            bin      <= '0;
            cmpValid <= 1'b0;
        end else begin
            cmpValid <= scanRdEn;
            case (state)
                IDLE: begin
                    if (eofPulse) begin
                        pixel <= '0;
                        bin   <= '0;
                        state <= READ;
                    end
                end
                READ: begin
                    // bin wraps to zero for the next pixel
                    bin <= bin + 1'b1;
                    if (lastBin) begin
                        state <= DRAIN;
                    end
                end
                // one extra cycle for the last bin's data
                DRAIN: state <= HOLD;
                HOLD: begin
                    // scan stays parked under back-pressure
                    if (peakReady) begin
                        if (lastPixel) begin
                            state <= IDLE;
                        end else begin
                            pixel <= pixel + 1'b1;
                            state <= READ;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // running max, bin 0 seeds it
    // strictly greater only, so ties keep the lower bin
    always_ff @(posedge clk) begin
        cmpBin <= bin;
        if (cmpValid) begin
            if ((cmpBin == '0) || (scanRdData > maxCount)) begin
                maxBin   <= cmpBin;
                maxCount <= scanRdData;
            end
        end
    end

endmodule

// ==== design/sifhTop.sv ====
`timescale 1ns/100ps

module sifhTop (
    input  logic               clk,
    input  logic               rstN,
    // wishbone classic slave
    input  logic               cyc,
    input  logic               stb,
    input  logic               we,
    input  logic [2:0]         adr,
    input  sifhPkg::timestampT dat,
    output logic               ack,
    // peak result stream
    output logic               peakValid,
    input  logic               peakReady,
    output sifhPkg::pixelIdxT  peakPixel,
    output sifhPkg::binIdxT    peakBin,
    output sifhPkg::countT     peakCount
);
    import sifhPkg::*;

    // binner to accumulator
    logic     busy;
    logic     hitValid;
    pixelIdxT hitPixel;
    binIdxT   hitBin;
    logic     eofPulse;

    // accumulator to peak finder
    logic     eofScan;
    logic     scanRdEn;
    histAddrT scanAddr;
    countT    scanRdData;
    logic     scanDone;

    timestampBinner uBinner (
        .clk      (clk),
        .rstN     (rstN),
        .cyc      (cyc),
        .stb      (stb),
        .we       (we),
        .adr      (adr),
        .dat      (dat),
        .ack      (ack),
        .busy     (busy),
        .hitValid (hitValid),
        .hitPixel (hitPixel),
        .hitBin   (hitBin),
        .eofPulse (eofPulse)
    );

    histogramAccumulator uAccum (
        .clk        (clk),
        .rstN       (rstN),
        .hitValid   (hitValid),
        .hitPixel   (hitPixel),
        .hitBin     (hitBin),
        .eofIn      (eofPulse),
        .eofOut     (eofScan),
        .busy       (busy),
        .scanRdEn   (scanRdEn),
        .scanAddr   (scanAddr),
        .scanRdData (scanRdData),
        .scanDone   (scanDone)
    );

    peakFinder uPeak (
        .clk        (clk),
        .rstN       (rstN),
        .eofPulse   (eofScan),
        .scanRdEn   (scanRdEn),
        .scanAddr   (scanAddr),
        .scanRdData (scanRdData),
        .scanDone   (scanDone),
        .peakValid  (peakValid),
        .peakReady  (peakReady),
        .peakPixel  (peakPixel),
        .peakBin    (peakBin),
        .peakCount  (peakCount)
    );

endmodule

// ==== verification/sifh_asserts.sv ====
`timescale 1ns/100ps

module sifhAsserts (
    input logic               clk,
    input logic               rstN,
    // wishbone side
    input logic               cyc,
    input logic               stb,
    input logic               ack,
    input logic               busy,
    // result stream
    input logic               peakValid,
    input logic               peakReady,
    input sifhPkg::pixelIdxT  peakPixel,
    input sifhPkg::binIdxT    peakBin,
    input sifhPkg::countT     peakCount
);
    import sifhPkg::*;

    // failures so far, watched by the testbench top
    int errCount = 0;

    // registered outputs come out of reset quiet
    resetQuiet: assert property (@(posedge clk) !rstN |=> (!ack && !peakValid))
        else begin
            $error("ack or peakValid high right after reset");
            errCount++;
        end

    // slave only answers an open strobe
    ackInCycle: assert property (@(posedge clk) disable iff (!rstN) ack |-> (cyc && stb))
        else begin
            $error("ack outside cyc and stb");
            errCount++;
        end

    // single-cycle ack per bus cycle
    ackSingle: assert property (@(posedge clk) disable iff (!rstN) ack |=> !ack)
        else begin
            $error("ack held for more than one cycle");
            errCount++;
        end

    // accept happened on the edge before, pipeline had to be free then
    ackNotBusy: assert property (@(posedge clk) disable iff (!rstN) ack |-> !$past(busy))
        else begin
            $error("ack given while the pipeline was busy");
            errCount++;
        end

    // result parked under back-pressure
    peakHeld: assert property (@(posedge clk) disable iff (!rstN)
        (peakValid && !peakReady) |=>
            (peakValid && $stable(peakPixel) && $stable(peakBin) && $stable(peakCount)))
        else begin
            $error("peak result changed while waiting for ready");
            errCount++;
        end

endmodule

bind sifhTop sifhAsserts uAsserts (
    .clk       (clk),
    .rstN      (rstN),
    .cyc       (cyc),
    .stb       (stb),
    .ack       (ack),
    .busy      (busy),
    .peakValid (peakValid),
    .peakReady (peakReady),
    .peakPixel (peakPixel),
    .peakBin   (peakBin),
    .peakCount (peakCount)
);

// ==== verification/sifhTb.sv ====
`timescale 1ns/100ps

module sifhTb;
    import sifhPkg::*;

    localparam int SEED = 60319;
    // cycles allowed for each wait
    localparam int TIMEOUT = 2000;
    localparam int RAND_HITS = 200;
    localparam int CLIP = (1 << COUNT_W) - 1;

    logic       clk;
    logic       rstN;
    logic       cyc;
    logic       stb;
    logic       we;
    logic [2:0] adr;
    timestampT  dat;
    logic       ack;
    logic       peakValid;
    logic       peakReady;
    pixelIdxT   peakPixel;
    binIdxT     peakBin;
    countT      peakCount;

    // reference counts per pixel and bin
    int model [PIXEL_NUM][BIN_NUM];

    sifhTop UUT (
        .clk       (clk),
        .rstN      (rstN),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .dat       (dat),
        .ack       (ack),
        .peakValid (peakValid),
        .peakReady (peakReady),
        .peakPixel (peakPixel),
        .peakBin   (peakBin),
        .peakCount (peakCount)
    );

    always #5 clk = ~clk;

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    // stop at the first bound assertion failure
    always @(posedge clk) begin
        if (UUT.uAsserts.errCount != 0) begin
            abortRun("a bus or stream protocol assertion failed");
        end
    end

    // one classic write held until ack is seen on a clock edge
    task automatic busWrite(input logic [2:0] addr, input timestampT data, output int waited);
        cyc = 1'b1;
        stb = 1'b1;
        we = 1'b1;
        adr = addr;
        dat = data;
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT) begin
                abortRun("timeout waiting for ack on the bus");
            end
        end while (!ack);
        @(posedge clk);
        #1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
    endtask

    // write a hit and count it the way the histogram should
    task automatic sendHit(input int pixel, input timestampT ts);
        int waited;
        int bin;
        busWrite(3'(pixel), ts, waited);
        bin = int'(ts >> BIN_SHIFT);
        if ((ts != NO_HIT) && (bin < BIN_NUM) && (model[pixel][bin] < CLIP)) begin
            model[pixel][bin]++;
        end
    endtask

    // hits clustered around one bin per pixel with some spread out
    task automatic randomFrame(input int hits);
        int center [PIXEL_NUM];
        int pixel;
        int bin;
        for (int p = 0; p < PIXEL_NUM; p++) begin
            center[p] = $urandom_range(BIN_NUM - 1);
        end
        for (int i = 0; i < hits; i++) begin
            pixel = $urandom_range(PIXEL_NUM - 1);
            if ($urandom_range(3) != 0) begin
                bin = (center[pixel] + $urandom_range(3)) % BIN_NUM;
            end else begin
                bin = $urandom_range(BIN_NUM - 1);
            end
            sendHit(pixel, timestampT'((bin << BIN_SHIFT) + $urandom_range((1 << BIN_SHIFT) - 1)));
        end
    endtask

    // later bins need a strictly larger count to win
    function automatic void expectedPeak(input int pixel, output int bin, output int count);
        bin = 0;
        count = model[pixel][0];
        for (int b = 1; b < BIN_NUM; b++) begin
            if (model[pixel][b] > count) begin
                bin = b;
                count = model[pixel][b];
            end
        end
    endfunction

    // close the frame and take one result per pixel in pixel order
    task automatic checkFrame(input bit stall);
        int waited;
        int expBin;
        int expCount;
        pixelIdxT seenPixel;
        binIdxT seenBin;
        countT seenCount;
        busWrite(EOF_ADR, '0, waited);
        for (int p = 0; p < PIXEL_NUM; p++) begin
            expectedPeak(p, expBin, expCount);
            waited = 0;
            while (!peakValid) begin
                @(posedge clk);
                #1;
                waited++;
                if (waited > TIMEOUT) begin
                    abortRun("timeout waiting for a peak result");
                end
            end
            seenPixel = peakPixel;
            seenBin = peakBin;
            seenCount = peakCount;
            // ready held low for a random stretch
            if (stall) begin
                repeat ($urandom_range(12, 1)) begin
                    @(posedge clk);
                    #1;
                end
                assert (peakValid && (peakPixel == seenPixel) && (peakBin == seenBin)
                        && (peakCount == seenCount))
                    else abortRun($sformatf(
                        "FAIL %0t: result for pixel %0d moved under back-pressure", $time, p));
            end
            assert ((int'(peakPixel) == p) && (int'(peakBin) == expBin)
                    && (int'(peakCount) == expCount))
                else abortRun($sformatf(
                    "FAIL %0t: got pixel %0d bin %0d count %0d, expected %0d %0d %0d",
                    $time, peakPixel, peakBin, peakCount, p, expBin, expCount));
            peakReady = 1'b1;
            @(posedge clk);
            #1;
            peakReady = 1'b0;
        end
        // memory was cleared by the scan
        model = '{default: 0};
    endtask

    initial begin
        int waited;
        void'($urandom(SEED));
        clk = 1'b0;
        rstN = 1'b0;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat = '0;
        peakReady = 1'b0;
        model = '{default: 0};
        repeat (16) @(posedge clk);
        #1;
        rstN = 1'b1;

        // first write waits out the clear sweep before an empty frame
        busWrite(3'd0, NO_HIT, waited);
        assert (waited >= HIST_DEPTH)
            else abortRun($sformatf("FAIL %0t: first write acked after %0d cycles, sweep is %0d",
                $time, waited, HIST_DEPTH));
        checkFrame(1'b0);

        randomFrame(RAND_HITS);
        checkFrame(1'b0);

        // same bin back to back and a tie on pixel 1
        repeat (20) sendHit(0, timestampT'(7 << BIN_SHIFT));
        repeat (5) begin
            sendHit(1, timestampT'((9 << BIN_SHIFT) + 3));
            sendHit(1, timestampT'((3 << BIN_SHIFT) + 17));
        end
        checkFrame(1'b0);

        // saturation on pixel 2 and no-hit markers on pixel 3
        repeat (300) sendHit(2, timestampT'(12 << BIN_SHIFT));
        repeat (10) sendHit(3, NO_HIT);
        repeat (3) sendHit(3, timestampT'(31 << BIN_SHIFT));
        checkFrame(1'b0);

        // stalled results and a fresh frame straight after
        randomFrame(RAND_HITS);
        checkFrame(1'b1);
        randomFrame(16);
        checkFrame(1'b0);

        if (UUT.uAsserts.errCount == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            abortRun("a bus or stream protocol assertion failed");
        end
    end

endmodule

// ==== flist.f ====
+incdir+common
common/sifhPkg.sv
design/timestampBinner.sv
histogram/histogramRam.sv
histogram/histogramAccumulator.sv
design/peakFinder.sv
design/sifhTop.sv
verification/sifh_asserts.sv
verification/sifhTb.sv

// ==== Bender.yml ====
package:
  name: sifh

sources:
  - include_dirs:
      - common
    files:
      - common/sifhPkg.sv
      - design/timestampBinner.sv
      - histogram/histogramRam.sv
      - histogram/histogramAccumulator.sv
      - design/peakFinder.sv
      - design/sifhTop.sv

  - target: test
    include_dirs:
      - common
    files:
      - verification/sifh_asserts.sv
      - verification/sifhTb.sv
